//--- Bender.yml
package:
  name: perf_counter_unit

sources:
  - design/perf_pkg.sv
  - design/perf_event_decode.sv
  - design/perf_csr_port.sv
  - design/perf_counter.sv
  - design/perf_csr_read.sv
  - design/perf_counter_unit.sv
  - target: test
    files:
      - tb/perf_counter_unit_checker.sv
      - tb/perf_counter_unit_tb.sv

//--- build.f
design/perf_pkg.sv
design/perf_event_decode.sv
design/perf_csr_port.sv
design/perf_counter.sv
design/perf_csr_read.sv
design/perf_counter_unit.sv
tb/perf_counter_unit_checker.sv
tb/perf_counter_unit_tb.sv

//--- design/perf_counter.sv
// Single 32-bit event counter
// CSR write beats increment; increment saturates or wraps per PCMR

`timescale 1ns/1ps

module perf_counter (
  input  logic                clk,
  input  logic                rst_ni,
  // Gated event strobe
  input  logic                inc_i,
  // CSR write path
  input  logic                sel_i,
  input  logic                wr_en_i,
  input  perf_pkg::csr_data_t wr_value_i,
  // Saturate mode from PCMR
  input  logic                sat_i,
  output perf_pkg::csr_data_t count_o
);

  import perf_pkg::*;

  csr_data_t count_nxt;

  // Next value, write has priority
  always_comb begin
    count_nxt = count_o;
    if (sel_i && wr_en_i) begin
      count_nxt = wr_value_i;
    end else if (inc_i) begin
      // Stick at all ones in saturate mode, else wrap to zero
      if (!(sat_i && (&count_o))) begin
        count_nxt = count_o + 32'd1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      count_o <= '0;
    end else begin
      count_o <= count_nxt;
    end
  end

endmodule

//--- design/perf_counter_unit.sv
// Performance counter unit top level
// Event decode, CSR port, counter bank and read path

`timescale 1ns/1ps

module perf_counter_unit #(
  parameter int unsigned N_EXT_CNT = 2
) (
  input  logic                 clk,
  input  logic                 rst_ni,
  // Event strobes
  input  logic                 id_valid_i,
  input  logic                 is_compressed_i,
  input  logic                 imiss_i,
  input  logic                 jump_i,
  input  logic                 branch_i,
  input  logic                 branch_taken_i,
  input  logic                 data_req_i,
  input  logic                 data_gnt_i,
  input  logic                 data_we_i,
  input  logic [N_EXT_CNT-1:0] ext_counters_i,
  // Core CSR port
  input  logic                 csr_access_i,
  input  perf_pkg::csr_op_e    csr_op_i,
  input  perf_pkg::csr_addr_t  csr_addr_i,
  input  perf_pkg::csr_data_t  csr_wdata_i,
  output perf_pkg::csr_data_t  csr_rdata_o,
  // Debug CSR port
  input  logic                 dbg_csr_req_i,
  input  perf_pkg::csr_addr_t  dbg_csr_addr_i,
  input  logic                 dbg_csr_we_i,
  input  perf_pkg::csr_data_t  dbg_csr_wdata_i
);

  import perf_pkg::*;

  localparam int unsigned N_CNT = N_INT_EVENTS + N_EXT_CNT;

  logic [N_CNT-1:0] events;
  logic [N_CNT-1:0] cnt_inc;
  logic [N_CNT-1:0] cnt_sel;
  logic             pcer_sel;
  logic             pcmr_sel;
  csr_op_e          op;
  csr_data_t        wdata;
  logic             wr_en;
  logic [N_CNT-1:0] pcer;
  logic [1:0]       pcmr;
  csr_data_t        wr_value;
  csr_data_t        counts [N_CNT];

  ////////////////////////////////////////////////////////////////////////////
  // Events and CSR port
  ////////////////////////////////////////////////////////////////////////////

  perf_event_decode #(
    .N_EXT_CNT ( N_EXT_CNT )
  ) u_event_decode (
    .id_valid_i      ( id_valid_i      ),
    .is_compressed_i ( is_compressed_i ),
    .imiss_i         ( imiss_i         ),
    .jump_i          ( jump_i          ),
    .branch_i        ( branch_i        ),
    .branch_taken_i  ( branch_taken_i  ),
    .data_req_i      ( data_req_i      ),
    .data_gnt_i      ( data_gnt_i      ),
    .data_we_i       ( data_we_i       ),
    .ext_counters_i  ( ext_counters_i  ),
    .events_o        ( events          )
  );

  perf_csr_port #(
    .N_EXT_CNT ( N_EXT_CNT )
  ) u_csr_port (
    .clk             ( clk             ),
    .rst_ni          ( rst_ni          ),
    .events_i        ( events          ),
    .csr_access_i    ( csr_access_i    ),
    .csr_op_i        ( csr_op_i        ),
    .csr_addr_i      ( csr_addr_i      ),
    .csr_wdata_i     ( csr_wdata_i     ),
    .dbg_csr_req_i   ( dbg_csr_req_i   ),
    .dbg_csr_addr_i  ( dbg_csr_addr_i  ),
    .dbg_csr_we_i    ( dbg_csr_we_i    ),
    .dbg_csr_wdata_i ( dbg_csr_wdata_i ),
    .wr_value_i      ( wr_value        ),
    .cnt_inc_o       ( cnt_inc         ),
    .cnt_sel_o       ( cnt_sel         ),
    .pcer_sel_o      ( pcer_sel        ),
    .pcmr_sel_o      ( pcmr_sel        ),
    .op_o            ( op              ),
    .wdata_o         ( wdata           ),
    .wr_en_o         ( wr_en           ),
    .pcer_o          ( pcer            ),
    .pcmr_o          ( pcmr            )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Counter bank
  ////////////////////////////////////////////////////////////////////////////

  // Saturate flag is shared by all counters
  for (genvar i = 0; i < N_CNT; i++) begin : g_cnt
    perf_counter u_counter (
      .clk        ( clk                ),
      .rst_ni     ( rst_ni             ),
      .inc_i      ( cnt_inc[i]         ),
      .sel_i      ( cnt_sel[i]         ),
      .wr_en_i    ( wr_en              ),
      .wr_value_i ( wr_value           ),
      .sat_i      ( pcmr[PCMR_SAT_BIT] ),
      .count_o    ( counts[i]          )
    );
  end

  // Read path closes the loop back into the port
  perf_csr_read #(
    .N_EXT_CNT ( N_EXT_CNT )
  ) u_csr_read (
    .counts_i   ( counts      ),
    .cnt_sel_i  ( cnt_sel     ),
    .pcer_sel_i ( pcer_sel    ),
    .pcmr_sel_i ( pcmr_sel    ),
    .pcer_i     ( pcer        ),
    .pcmr_i     ( pcmr        ),
    .op_i       ( op          ),
    .wdata_i    ( wdata       ),
    .rdata_o    ( csr_rdata_o ),
    .wr_value_o ( wr_value    )
  );

endmodule

//--- design/perf_csr_port.sv
// CSR access port of the performance counter unit
// Debug/core arbitration, address decode, PCER and PCMR, increment gating

`timescale 1ns/1ps

module perf_csr_port #(
  parameter int unsigned N_EXT_CNT = 2,
  localparam int unsigned N_CNT = perf_pkg::N_INT_EVENTS + N_EXT_CNT
) (
  input  logic                clk,
  input  logic                rst_ni,
  // Raw events from the decoder
  input  logic [N_CNT-1:0]    events_i,
  // Core CSR port
  input  logic                csr_access_i,
  input  perf_pkg::csr_op_e   csr_op_i,
  input  perf_pkg::csr_addr_t csr_addr_i,
  input  perf_pkg::csr_data_t csr_wdata_i,
  // Debug CSR port
  input  logic                dbg_csr_req_i,
  input  perf_pkg::csr_addr_t dbg_csr_addr_i,
  input  logic                dbg_csr_we_i,
  input  perf_pkg::csr_data_t dbg_csr_wdata_i,
  // Read-modify-write result from the read path
  input  perf_pkg::csr_data_t wr_value_i,
  // To the counter bank and read path
  output logic [N_CNT-1:0]    cnt_inc_o,
  output logic [N_CNT-1:0]    cnt_sel_o,
  output logic                pcer_sel_o,
  output logic                pcmr_sel_o,
  output perf_pkg::csr_op_e   op_o,
  output perf_pkg::csr_data_t wdata_o,
  output logic                wr_en_o,
  output logic [N_CNT-1:0]    pcer_o,
  output logic [1:0]          pcmr_o
);

  import perf_pkg::*;

  logic       access;
  csr_addr_t  addr;
  logic [N_CNT-1:0] pcer_q;
  logic [1:0] pcmr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Source select
  ////////////////////////////////////////////////////////////////////////////

  // Debug request steals the port for the whole cycle
  always_comb begin
    if (dbg_csr_req_i) begin
      access  = 1'b1;
      addr    = dbg_csr_addr_i;
      wdata_o = dbg_csr_wdata_i;
      op_o    = dbg_csr_we_i ? CSR_OP_WRITE : CSR_OP_NONE;
    end else begin
      access  = csr_access_i;
      addr    = csr_addr_i;
      wdata_o = csr_wdata_i;
      op_o    = csr_access_i ? csr_op_i : CSR_OP_NONE;
    end
  end

  assign wr_en_o = (op_o != CSR_OP_NONE);

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  // One-hot selects, all zero when idle or unmapped
  always_comb begin
    for (int i = 0; i < N_CNT; i++) begin
      cnt_sel_o[i] = access && (addr == csr_addr_t'(PCCR_BASE + i));
    end
  end

  assign pcer_sel_o = access && (addr == PCER_ADDR);
  assign pcmr_sel_o = access && (addr == PCMR_ADDR);

  ////////////////////////////////////////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////////////////////////////////////////

  // All counters enabled, global enable and saturate on out of reset
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      pcer_q <= '1;
      pcmr_q <= 2'b11;
    end else begin
      if (pcer_sel_o && wr_en_o) begin
        pcer_q <= wr_value_i[N_CNT-1:0];
      end
      if (pcmr_sel_o && wr_en_o) begin
        pcmr_q <= wr_value_i[1:0];
      end
    end
  end

  assign pcer_o = pcer_q;
  assign pcmr_o = pcmr_q;

  // Event counts only if enabled per counter and globally
  assign cnt_inc_o = events_i & pcer_q & {N_CNT{pcmr_q[PCMR_EN_BIT]}};

endmodule

//--- design/perf_csr_read.sv
// CSR read mux of the performance counter unit
// Returns the selected register and forms the write/set/clear value

`timescale 1ns/1ps

module perf_csr_read #(
  parameter int unsigned N_EXT_CNT = 2,
  localparam int unsigned N_CNT = perf_pkg::N_INT_EVENTS + N_EXT_CNT
) (
  // Counter bank
  input  perf_pkg::csr_data_t counts_i [N_CNT],
  // One-hot selects from the port
  input  logic [N_CNT-1:0]    cnt_sel_i,
  input  logic                pcer_sel_i,
  input  logic                pcmr_sel_i,
  // Control register values
  input  logic [N_CNT-1:0]    pcer_i,
  input  logic [1:0]          pcmr_i,
  // Effective access
  input  perf_pkg::csr_op_e   op_i,
  input  perf_pkg::csr_data_t wdata_i,
  output perf_pkg::csr_data_t rdata_o,
  output perf_pkg::csr_data_t wr_value_o
);

  import perf_pkg::*;

  csr_data_t cnt_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////

  // AND-OR mux, selects are one-hot
  always_comb begin
    cnt_rdata = '0;
    for (int i = 0; i < N_CNT; i++) begin
      cnt_rdata = cnt_rdata | (counts_i[i] & {32{cnt_sel_i[i]}});
    end
  end

  // Unmapped addresses fall through to zero
  always_comb begin
    rdata_o = cnt_rdata;
    if (pcer_sel_i) begin
      rdata_o = csr_data_t'(pcer_i);
    end else if (pcmr_sel_i) begin
      rdata_o = {30'd0, pcmr_i};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read-modify-write
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (op_i)
      CSR_OP_WRITE: wr_value_o = wdata_i;
      CSR_OP_SET:   wr_value_o = rdata_o | wdata_i;
      CSR_OP_CLEAR: wr_value_o = rdata_o & ~wdata_i;
      // No write happens, keep the old value
      default:      wr_value_o = rdata_o;
    endcase
  end

endmodule

//--- design/perf_event_decode.sv
// Event decode for the performance counters
// Maps pipeline strobes and the data-bus handshake onto one event vector

`timescale 1ns/1ps

module perf_event_decode #(
  parameter int unsigned N_EXT_CNT = 2,
  localparam int unsigned N_CNT = perf_pkg::N_INT_EVENTS + N_EXT_CNT
) (
  // Pipeline strobes
  input  logic                 id_valid_i,
  input  logic                 is_compressed_i,
  input  logic                 imiss_i,
  input  logic                 jump_i,
  input  logic                 branch_i,
  input  logic                 branch_taken_i,
  // Data bus handshake
  input  logic                 data_req_i,
  input  logic                 data_gnt_i,
  input  logic                 data_we_i,
  // External events, one per external counter
  input  logic [N_EXT_CNT-1:0] ext_counters_i,
  output logic [N_CNT-1:0]     events_o
);

  import perf_pkg::*;

  // Bus transfer only counts once the request is granted
  logic data_xfer;

  assign data_xfer = data_req_i & data_gnt_i;

  always_comb begin
    events_o = '0;
    // Cycle counter runs every clock
    events_o[EV_CYCLES]     = 1'b1;
    events_o[EV_INSTR]      = id_valid_i;
    events_o[EV_IMISS]      = imiss_i;
    // Split granted transfers by direction
    events_o[EV_LOAD]       = data_xfer & ~data_we_i;
    events_o[EV_STORE]      = data_xfer & data_we_i;
    events_o[EV_JUMP]       = jump_i;
    events_o[EV_BRANCH]     = branch_i;
    events_o[EV_TBRANCH]    = branch_taken_i;
    // Compressed only for instructions that actually decode
    events_o[EV_COMPRESSED] = id_valid_i & is_compressed_i;
    // External events sit above the internal ones
    events_o[N_CNT-1:N_INT_EVENTS] = ext_counters_i;
  end

endmodule

//--- design/perf_pkg.sv
// Shared types and constants of the performance counter unit
// CSR map, CSR operation codes and internal event indices

package perf_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // CSR types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  // Encoding follows the core's CSR operation field
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////////////////////

  // Counter i sits at PCCR_BASE + i
  localparam csr_addr_t PCCR_BASE = 12'h780;
  localparam csr_addr_t PCER_ADDR = 12'h7A0;
  localparam csr_addr_t PCMR_ADDR = 12'h7A1;

  // PCMR fields
  localparam int unsigned PCMR_EN_BIT  = 0;
  localparam int unsigned PCMR_SAT_BIT = 1;

  ////////////////////////////////////////////////////////////////////////////
  // Internal events
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned N_INT_EVENTS = 9;

  localparam int unsigned EV_CYCLES     = 0;
  localparam int unsigned EV_INSTR      = 1;
  localparam int unsigned EV_IMISS      = 2;
  localparam int unsigned EV_LOAD       = 3;
  localparam int unsigned EV_STORE      = 4;
  localparam int unsigned EV_JUMP       = 5;
  localparam int unsigned EV_BRANCH     = 6;
  localparam int unsigned EV_TBRANCH    = 7;
  localparam int unsigned EV_COMPRESSED = 8;

endpackage

//--- tb/perf_counter_unit_checker.sv
// Bound assertions for the performance counter unit
// Known read data, zero on unmapped reads, cycle counter stepping

`timescale 1ns/1ps

module perf_counter_unit_checker #(
  parameter int unsigned N_EXT_CNT = 2,
  localparam int unsigned N_CNT = perf_pkg::N_INT_EVENTS + N_EXT_CNT
) (
  input logic                clk,
  input logic                rst_ni,
  input logic                csr_access_i,
  input perf_pkg::csr_op_e   csr_op_i,
  input perf_pkg::csr_addr_t csr_addr_i,
  input logic                dbg_csr_req_i,
  input perf_pkg::csr_addr_t dbg_csr_addr_i,
  input logic                dbg_csr_we_i,
  input perf_pkg::csr_data_t csr_rdata_i,
  input logic [N_CNT-1:0]    pcer_i,
  input logic [1:0]          pcmr_i
);

  import perf_pkg::*;

  logic      access;
  csr_addr_t addr;
  logic      mapped;
  logic      cyc_read;

  // Number of assertion failures so far
  int unsigned fail_cnt = 0;

  // Effective access once debug has taken the port
  assign access = dbg_csr_req_i | csr_access_i;
  assign addr   = dbg_csr_req_i ? dbg_csr_addr_i : csr_addr_i;
  assign mapped = ((addr >= PCCR_BASE) && (addr < PCCR_BASE + N_CNT)) ||
                  (addr == PCER_ADDR) || (addr == PCMR_ADDR);

  // Plain read of the cycle counter, no write from either port
  assign cyc_read = dbg_csr_req_i ? (!dbg_csr_we_i && (dbg_csr_addr_i == PCCR_BASE))
                                  : (csr_access_i && (csr_op_i == CSR_OP_NONE) &&
                                     (csr_addr_i == PCCR_BASE));

  a_rdata_known: assert property (@(posedge clk) disable iff (!rst_ni)
    !$isunknown(csr_rdata_i))
    else begin
      fail_cnt++;
      $error("CSR read data has X or Z bits");
    end

  a_unmapped_zero: assert property (@(posedge clk) disable iff (!rst_ni)
    (access && !mapped) |-> (csr_rdata_i == '0))
    else begin
      fail_cnt++;
      $error("Unmapped CSR address returned nonzero data");
    end

  // Enabled cycle counter moves by one between back-to-back reads
  a_cycle_step: assert property (@(posedge clk) disable iff (!rst_ni)
    (cyc_read && pcmr_i[PCMR_EN_BIT] && pcer_i[EV_CYCLES]) ##1 cyc_read |->
      (csr_rdata_i == $past(csr_rdata_i) + 32'd1) ||
      ((csr_rdata_i == '1) && ($past(csr_rdata_i) == '1)))
    else begin
      fail_cnt++;
      $error("Cycle counter did not step by one between reads");
    end

endmodule

//--- tb/perf_counter_unit_tb.sv
// Testbench for the performance counter unit
// Random and directed CSR traffic compared against a cycle model

`timescale 1ns/1ps

module perf_counter_unit_tb;

  import perf_pkg::*;

  localparam int unsigned N_EXT_CNT = 2;
  localparam int unsigned N_CNT = N_INT_EVENTS + N_EXT_CNT;
  // Whole sequence runs about 1300 cycles
  localparam int unsigned TIMEOUT_CYCLES = 8000;

  typedef enum logic [1:0] {CHK_NONE, CHK_CNT, CHK_CTRL} chk_kind_e;

  logic clk;
  logic rst_ni;
  logic id_valid_i, is_compressed_i, imiss_i, jump_i, branch_i, branch_taken_i;
  logic data_req_i, data_gnt_i, data_we_i;
  logic [N_EXT_CNT-1:0] ext_counters_i;
  logic      csr_access_i;
  csr_op_e   csr_op_i;
  csr_addr_t csr_addr_i;
  csr_data_t csr_wdata_i;
  csr_data_t csr_rdata_o;
  logic      dbg_csr_req_i;
  csr_addr_t dbg_csr_addr_i;
  logic      dbg_csr_we_i;
  csr_data_t dbg_csr_wdata_i;

  // Model state
  csr_data_t        m_cnt [N_CNT];
  logic [N_CNT-1:0] m_pcer;
  logic [1:0]       m_pcmr;

  // Pending check, posted at the falling edge
  chk_kind_e   chk_kind;
  int unsigned chk_idx;
  csr_data_t   chk_exp;
  string       test_name;
  logic [31:0] lcg_state;
  int unsigned cycle_cnt;

  perf_counter_unit #(
    .N_EXT_CNT ( N_EXT_CNT )
  ) dut (.*);

  bind perf_counter_unit perf_counter_unit_checker #(
    .N_EXT_CNT ( N_EXT_CNT )
  ) u_checker (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .csr_access_i   ( csr_access_i   ),
    .csr_op_i       ( csr_op_i       ),
    .csr_addr_i     ( csr_addr_i     ),
    .dbg_csr_req_i  ( dbg_csr_req_i  ),
    .dbg_csr_addr_i ( dbg_csr_addr_i ),
    .dbg_csr_we_i   ( dbg_csr_we_i   ),
    .csr_rdata_i    ( csr_rdata_o    ),
    .pcer_i         ( pcer           ),
    .pcmr_i         ( pcmr           )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Read data of this cycle, then model state after the closing edge
  function automatic csr_data_t ref_cycle();
    logic [N_CNT-1:0] ev;
    logic [N_CNT-1:0] inc;
    logic             acc;
    csr_addr_t        addr;
    csr_op_e          op;
    csr_data_t        wdata;
    csr_data_t        rdata;
    csr_data_t        wval;
    ev = '0;
    ev[EV_CYCLES]     = 1'b1;
    ev[EV_INSTR]      = id_valid_i;
    ev[EV_IMISS]      = imiss_i;
    ev[EV_LOAD]       = data_req_i && data_gnt_i && !data_we_i;
    ev[EV_STORE]      = data_req_i && data_gnt_i && data_we_i;
    ev[EV_JUMP]       = jump_i;
    ev[EV_BRANCH]     = branch_i;
    ev[EV_TBRANCH]    = branch_taken_i;
    ev[EV_COMPRESSED] = id_valid_i && is_compressed_i;
    for (int k = 0; k < N_EXT_CNT; k++) begin
      ev[N_INT_EVENTS + k] = ext_counters_i[k];
    end
    // Debug wins the port, and can only read or write
    acc   = dbg_csr_req_i || csr_access_i;
    addr  = dbg_csr_req_i ? dbg_csr_addr_i : csr_addr_i;
    wdata = dbg_csr_req_i ? dbg_csr_wdata_i : csr_wdata_i;
    op    = CSR_OP_NONE;
    if (dbg_csr_req_i && dbg_csr_we_i) begin
      op = CSR_OP_WRITE;
    end else if (!dbg_csr_req_i && csr_access_i) begin
      op = csr_op_i;
    end
    rdata = '0;
    if (acc && (addr >= PCCR_BASE) && (addr < PCCR_BASE + N_CNT)) begin
      rdata = m_cnt[addr - PCCR_BASE];
    end else if (acc && (addr == PCER_ADDR)) begin
      rdata[N_CNT-1:0] = m_pcer;
    end else if (acc && (addr == PCMR_ADDR)) begin
      rdata[1:0] = m_pcmr;
    end
    case (op)
      CSR_OP_WRITE: wval = wdata;
      CSR_OP_SET:   wval = rdata | wdata;
      CSR_OP_CLEAR: wval = rdata & ~wdata;
      default:      wval = rdata;
    endcase
    // Enables as they stood during this cycle
    inc = ev & m_pcer & {N_CNT{m_pcmr[PCMR_EN_BIT]}};
    for (int i = 0; i < N_CNT; i++) begin
      if ((op != CSR_OP_NONE) && (addr == PCCR_BASE + i)) begin
        m_cnt[i] = wval;
      end else if (inc[i] && !(m_pcmr[PCMR_SAT_BIT] && (m_cnt[i] == '1))) begin
        m_cnt[i] = m_cnt[i] + 32'd1;
      end
    end
    if ((op != CSR_OP_NONE) && (addr == PCER_ADDR)) begin
      m_pcer = wval[N_CNT-1:0];
    end
    if ((op != CSR_OP_NONE) && (addr == PCMR_ADDR)) begin
      m_pcmr = wval[1:0];
    end
    return rdata;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_counter(string name, int unsigned idx, csr_data_t exp,
                               csr_data_t act);
    if (act !== exp) begin
      $display("ERR %s: counter %0d expected %08h actual %08h", name, idx, exp, act);
      $display("Test failed");
      $fatal(1, "counter read mismatch");
    end
  endtask

  task automatic check_ctrl(string name, csr_data_t exp, csr_data_t act);
    if (act !== exp) begin
      $display("ERR %s: control read expected %08h actual %08h", name, exp, act);
      $display("Test failed");
      $fatal(1, "control register read mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks, each one cycle from falling edge to falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic set_idle();
    {id_valid_i, is_compressed_i, imiss_i, jump_i, branch_i, branch_taken_i} = '0;
    {data_req_i, data_gnt_i, data_we_i} = '0;
    ext_counters_i  = '0;
    csr_access_i    = 1'b0;
    csr_op_i        = CSR_OP_NONE;
    csr_addr_i      = '0;
    csr_wdata_i     = '0;
    dbg_csr_req_i   = 1'b0;
    dbg_csr_we_i    = 1'b0;
    dbg_csr_addr_i  = '0;
    dbg_csr_wdata_i = '0;
  endtask

  // Includes requests without grant
  task automatic random_events();
    logic [31:0] r;
    r = lcg_next();
    {id_valid_i, is_compressed_i, imiss_i, jump_i, branch_i} = r[31:27];
    {data_req_i, data_gnt_i, data_we_i} = r[26:24];
    branch_taken_i = r[27] & r[23];
    ext_counters_i = r[16 +: N_EXT_CNT];
  endtask

  task automatic drive_core(csr_op_e op, csr_addr_t addr, csr_data_t wdata);
    csr_access_i = 1'b1;
    csr_op_i     = op;
    csr_addr_i   = addr;
    csr_wdata_i  = wdata;
  endtask

  task automatic end_cycle(chk_kind_e kind, int unsigned idx);
    chk_exp  = ref_cycle();
    chk_kind = kind;
    chk_idx  = idx;
    @(negedge clk);
  endtask

  task automatic idle_cycles(int n, bit rnd);
    repeat (n) begin
      set_idle();
      if (rnd) begin
        random_events();
      end
      end_cycle(CHK_NONE, 0);
    end
  endtask

  task automatic core_csr(csr_op_e op, csr_addr_t addr, csr_data_t wdata,
                          chk_kind_e kind, int unsigned idx, bit rnd);
    set_idle();
    if (rnd) begin
      random_events();
    end
    drive_core(op, addr, wdata);
    end_cycle(kind, idx);
  endtask

  task automatic read_cnt(int unsigned idx, bit rnd);
    core_csr(CSR_OP_NONE, csr_addr_t'(PCCR_BASE + idx), '0, CHK_CNT, idx, rnd);
  endtask

  task automatic read_ctrl(csr_addr_t addr);
    core_csr(CSR_OP_NONE, addr, '0, CHK_CTRL, 0, 1'b0);
  endtask

  task automatic read_all();
    for (int i = 0; i < N_CNT; i++) begin
      read_cnt(i, 1'b0);
    end
  endtask

  task automatic jump_cycles(int n);
    repeat (n) begin
      set_idle();
      jump_i = 1'b1;
      end_cycle(CHK_NONE, 0);
    end
  endtask

  // Core hits the same register with other data in the same cycle
  task automatic dbg_csr(logic we, csr_addr_t addr, csr_data_t wdata, csr_op_e core_op,
                         chk_kind_e kind, int unsigned idx);
    set_idle();
    drive_core(core_op, addr, ~wdata);
    dbg_csr_req_i   = 1'b1;
    dbg_csr_we_i    = we;
    dbg_csr_addr_i  = addr;
    dbg_csr_wdata_i = wdata;
    end_cycle(kind, idx);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Processes
  ////////////////////////////////////////////////////////////////////////////

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // Read data settles well before the rising edge
  initial begin : compare_proc
    forever begin
      @(negedge clk);
      #1;
      case (chk_kind)
        CHK_CNT:  check_counter(test_name, chk_idx, chk_exp, csr_rdata_o);
        CHK_CTRL: check_ctrl(test_name, chk_exp, csr_rdata_o);
        default:  ;
      endcase
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: test sequence still running after %0d cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $fatal(1, "timeout");
  end

  initial begin : stimulus
    logic [31:0]      rnd;
    logic [N_CNT-1:0] mask;
    lcg_state = 32'ha762_f094;
    chk_kind  = CHK_NONE;
    chk_idx   = 0;
    chk_exp   = '0;
    test_name = "reset_values";
    rst_ni    = 1'b0;
    set_idle();
    m_pcer = '1;
    m_pcmr = 2'b11;
    for (int i = 0; i < N_CNT; i++) begin
      m_cnt[i] = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_ni = 1'b1;

    // 1. Reset values, counter 0 read before it moves
    read_all();
    read_ctrl(PCER_ADDR);
    read_ctrl(PCMR_ADDR);
    read_ctrl(12'h7A2);
    core_csr(CSR_OP_WRITE, csr_addr_t'(PCCR_BASE + N_CNT), '1, CHK_CTRL, 0, 1'b0);
    read_ctrl(csr_addr_t'(PCCR_BASE + N_CNT));
    repeat (3) read_cnt(EV_CYCLES, 1'b0);

    // 2. Random strobes
    test_name = "random_events";
    idle_cycles(500, 1'b1);
    read_all();

    // 3. PCER mask, loads frozen and instructions kept running
    test_name = "pcer_mask";
    rnd  = lcg_next();
    mask = rnd[N_CNT-1:0];
    mask[EV_LOAD]  = 1'b1;
    mask[EV_INSTR] = 1'b0;
    core_csr(CSR_OP_CLEAR, PCER_ADDR, csr_data_t'(mask), CHK_CTRL, 0, 1'b1);
    read_ctrl(PCER_ADDR);
    idle_cycles(200, 1'b1);
    read_all();
    core_csr(CSR_OP_SET, PCER_ADDR, csr_data_t'(mask), CHK_CTRL, 0, 1'b1);
    read_ctrl(PCER_ADDR);
    idle_cycles(100, 1'b1);
    read_all();

    // 4. Global enable off, then back on
    test_name = "pcmr_enable";
    core_csr(CSR_OP_CLEAR, PCMR_ADDR, 32'd1 << PCMR_EN_BIT, CHK_CTRL, 0, 1'b1);
    read_ctrl(PCMR_ADDR);
    idle_cycles(100, 1'b1);
    read_all();
    core_csr(CSR_OP_SET, PCMR_ADDR, 32'd1 << PCMR_EN_BIT, CHK_CTRL, 0, 1'b1);
    repeat (4) read_cnt(EV_CYCLES, 1'b1);
    idle_cycles(100, 1'b1);
    read_all();

    // 5. Saturate, wrap, write against event
    test_name = "saturation";
    core_csr(CSR_OP_WRITE, csr_addr_t'(PCCR_BASE + EV_JUMP), 32'hFFFF_FFFD, CHK_CNT,
             EV_JUMP, 1'b0);
    jump_cycles(4);
    read_cnt(EV_JUMP, 1'b0);
    core_csr(CSR_OP_CLEAR, PCMR_ADDR, 32'd1 << PCMR_SAT_BIT, CHK_CTRL, 0, 1'b0);
    jump_cycles(1);
    read_cnt(EV_JUMP, 1'b0);
    set_idle();
    jump_i = 1'b1;
    drive_core(CSR_OP_WRITE, csr_addr_t'(PCCR_BASE + EV_JUMP), 32'h1234_5678);
    end_cycle(CHK_CNT, EV_JUMP);
    read_cnt(EV_JUMP, 1'b0);
    core_csr(CSR_OP_SET, PCMR_ADDR, 32'd1 << PCMR_SAT_BIT, CHK_CTRL, 0, 1'b0);

    // 6. Debug port against a concurrent core access
    test_name = "debug_priority";
    dbg_csr(1'b0, csr_addr_t'(PCCR_BASE + EV_INSTR), '0, CSR_OP_WRITE, CHK_CNT, EV_INSTR);
    read_cnt(EV_INSTR, 1'b0);
    dbg_csr(1'b1, csr_addr_t'(PCCR_BASE + EV_TBRANCH), 32'hCAFE_0007, CSR_OP_SET,
            CHK_CNT, EV_TBRANCH);
    read_cnt(EV_TBRANCH, 1'b0);
    dbg_csr(1'b1, PCER_ADDR, 32'h0000_07F0, CSR_OP_CLEAR, CHK_CTRL, 0);
    dbg_csr(1'b0, PCER_ADDR, '0, CSR_OP_WRITE, CHK_CTRL, 0);
    dbg_csr(1'b1, PCER_ADDR, '1, CSR_OP_CLEAR, CHK_CTRL, 0);
    idle_cycles(20, 1'b1);
    read_all();

    // Last posted check has already been compared
    chk_kind = CHK_NONE;
    #2;
    // Bound assertions only count their failures
    if (dut.u_checker.fail_cnt == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "%0d bound assertion failures", dut.u_checker.fail_cnt);
    end
  end

endmodule
